// File: sim.f
hdl/exec_pkg.sv
hdl/alu.sv
hdl/alu_control.sv
hdl/register_file.sv
hdl/issue_stage.sv
hdl/writeback_stage.sv
hdl/exec_core.sv
sim/exec_checker.sv
sim/exec_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module exec_core_tb -o exec_core_tb \
	&& ./obj_dir/exec_core_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: sim/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;
	import exec_pkg::*;

	localparam int fixed_count = 34;
	localparam int random_count = 16;
	localparam int table_len = fixed_count + random_count;
	localparam int cycle_limit = table_len * 2 + 20;	// Two cycles per entry plus margin

	logic clk;
	logic rst_n;
	logic instr_strobe;
	word_t instr;
	logic result_valid;
	word_t result;
	logic wr_en;
	reg_addr_t wr_addr;
	logic branch_taken;

	int checked_count;
	int mismatch_count;
	int other_count;
	int run_cycles;
	logic [31:0] lfsr_state;
	word_t stim [table_len];	// Instruction words in issue order

	always #20 clk = ~clk;	// 40 ns period

	exec_core exec_core_inst (.clk, .rst_n, .instr_strobe, .instr, .result_valid, .result,
		.wr_en, .wr_addr, .branch_taken);

	exec_checker exec_checker_inst (.clk, .rst_n, .instr_strobe, .instr, .result_valid,
		.result, .wr_en, .wr_addr, .branch_taken, .checked_count, .mismatch_count,
		.other_count);

	function automatic word_t rtype_word(input reg_addr_t rs, input reg_addr_t rt,
			input reg_addr_t rd, input logic [5:0] fn);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t itype_word(input logic [5:0] op, input reg_addr_t rs,
			input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic load_fixed_entries();
		stim[0]  = itype_word(op_lui, 5'd0, 5'd1, 16'h8000);	// r1 8000_0000
		stim[1]  = itype_word(op_ori, 5'd1, 5'd1, 16'h0001);	// r1 8000_0001
		stim[2]  = itype_word(op_lui, 5'd0, 5'd2, 16'h1234);
		stim[3]  = itype_word(op_ori, 5'd2, 5'd2, 16'h5678);	// r2 1234_5678
		stim[4]  = itype_word(op_addiu, 5'd0, 5'd3, 16'hffff);	// r3 all ones
		stim[5]  = itype_word(op_ori, 5'd0, 5'd4, 16'h00ff);
		stim[6]  = itype_word(op_addi, 5'd0, 5'd5, 16'h0005);
		stim[7]  = itype_word(op_lui, 5'd0, 5'd0, 16'habcd);	// Dropped r0 write
		stim[8]  = rtype_word(5'd0, 5'd0, 5'd6, fn_or);	// r0 still zero
		stim[9]  = rtype_word(5'd2, 5'd4, 5'd7, fn_add);
		stim[10] = rtype_word(5'd1, 5'd3, 5'd8, fn_addu);	// Wraps to 8000_0000
		stim[11] = rtype_word(5'd4, 5'd5, 5'd9, fn_sub);
		stim[12] = rtype_word(5'd5, 5'd4, 5'd10, fn_subu);	// Negative difference
		stim[13] = rtype_word(5'd2, 5'd4, 5'd11, fn_and);
		stim[14] = rtype_word(5'd1, 5'd4, 5'd12, fn_or);
		stim[15] = rtype_word(5'd2, 5'd3, 5'd13, fn_xor);
		stim[16] = rtype_word(5'd4, 5'd5, 5'd14, fn_nor);
		stim[17] = itype_word(op_andi, 5'd3, 5'd15, 16'h8001);	// Zero-extended
		stim[18] = itype_word(op_xori, 5'd2, 5'd16, 16'hffff);
		stim[19] = itype_word(op_addi, 5'd5, 5'd17, 16'hfff0);	// 5 - 16
		stim[20] = rtype_word(5'd1, 5'd5, 5'd18, fn_slt);	// Negative < 5
		stim[21] = rtype_word(5'd1, 5'd5, 5'd19, fn_sltu);	// Large unsigned, 0
		stim[22] = itype_word(op_slti, 5'd3, 5'd20, 16'h0000);
		stim[23] = itype_word(op_sltiu, 5'd4, 5'd21, 16'hffff);
		stim[24] = itype_word(op_slti, 5'd5, 5'd22, 16'h8000);	// 5 < -32768 is 0
		stim[25] = itype_word(op_beq, 5'd4, 5'd4, 16'h0010);	// Taken
		stim[26] = itype_word(op_beq, 5'd4, 5'd5, 16'h0010);
		stim[27] = itype_word(op_bne, 5'd4, 5'd5, 16'h0020);	// Taken
		stim[28] = itype_word(op_regimm, 5'd5, 5'd1, 16'h0004);	// BGEZ taken
		stim[29] = itype_word(op_regimm, 5'd1, 5'd1, 16'h0004);	// BGEZ negative
		stim[30] = rtype_word(5'd2, 5'd5, 5'd23, fn_movn);	// rt nonzero, writes
		stim[31] = rtype_word(5'd2, 5'd0, 5'd24, fn_movn);	// No write
		stim[32] = itype_word(6'h3f, 5'd1, 5'd2, 16'h1234);	// Unknown opcode
		stim[33] = rtype_word(5'd2, 5'd4, 5'd25, 6'h3f);	// Unknown funct
	endtask

	task automatic fill_random_entries();
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [15:0] imm;
		for (int k = 0; k < random_count; k++) begin
			rs = reg_addr_t'(lfsr_bits(3));	// Sources r0..r7
			rt = reg_addr_t'(lfsr_bits(3));
			rd = reg_addr_t'(lfsr_bits(3)) + 5'd8;	// Targets r8..r15
			imm = 16'(lfsr_bits(16));
			case (k % 8)
				0: stim[fixed_count + k] = itype_word(op_addi, rs, rd, imm);
				1: stim[fixed_count + k] = itype_word(op_andi, rs, rd, imm);
				2: stim[fixed_count + k] = itype_word(op_xori, rs, rd, imm);
				3: stim[fixed_count + k] = itype_word(op_sltiu, rs, rd, imm);
				4: stim[fixed_count + k] = rtype_word(rs, rt, rd, fn_add);
				5: stim[fixed_count + k] = rtype_word(rs, rt, rd, fn_subu);
				6: stim[fixed_count + k] = rtype_word(rs, rt, rd, fn_slt);
				default: stim[fixed_count + k] = itype_word(op_bne, rs, rt, imm);
			endcase
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr_strobe = 1'b0;
		instr = '0;
		lfsr_state = 32'h36d1_60b9;
		load_fixed_entries();
		fill_random_entries();
		repeat (5) @(posedge clk);
		#2 rst_n = 1'b1;
		for (int i = 0; i < table_len; i++) begin
			@(posedge clk);
			#2;
			instr_strobe = 1'b1;
			instr = stim[i];
			@(posedge clk);
			#2;
			instr_strobe = 1'b0;	// Idle cycle, write lands before next read
		end
		while (checked_count < table_len) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);	// Room for a stray result_valid
		$display("checked %0d of %0d instructions, %0d mismatches, %0d other errors",
			checked_count, table_len, mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		run_cycles = run_cycles + 1;
		if (run_cycles >= cycle_limit) begin
			$display("timeout after %0d cycles with %0d of %0d instructions checked",
				run_cycles, checked_count, table_len);
			$display("tests failed");
			$finish;
		end
	end

endmodule

// File: sim/exec_checker.sv
`timescale 1ns/1ps

module exec_checker (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_strobe,
	input  exec_pkg::word_t     instr,
	input  logic                result_valid,
	input  exec_pkg::word_t     result,
	input  logic                wr_en,
	input  exec_pkg::reg_addr_t wr_addr,
	input  logic                branch_taken,
	output int                  checked_count,
	output int                  mismatch_count,
	output int                  other_count
);
	import exec_pkg::*;

	typedef struct packed {
		word_t       instr;
		word_t       result;
		logic        wr_en;
		reg_addr_t   wr_addr;
		logic        branch;
		logic [31:0] cycle;	// Cycle of the strobe
	} expect_t;

	word_t model [32];	// Register image after each strobe
	expect_t pending [$];	// In flight, oldest first
	logic [31:0] cycle_count;

	function automatic word_t flag_word(input logic f);
		return {31'b0, f};
	endfunction

	// Expected outputs from the instruction rules
	function automatic expect_t predict(input word_t w);
		expect_t e;
		word_t a;
		word_t b;
		word_t sx;
		word_t zx;
		a = model[w[25:21]];
		b = model[w[20:16]];
		sx = {{16{w[15]}}, w[15:0]};	// Sign-extended immediate
		zx = {16'h0, w[15:0]};
		e = '0;
		e.instr = w;
		e.result = bad_result;	// Unknown encodings
		e.wr_addr = w[20:16];	// I-type target is rt
		case (w[31:26])
			op_rtype: begin
				e.wr_addr = w[15:11];
				e.wr_en = 1'b1;
				case (w[5:0])
					fn_and:  e.result = a & b;
					fn_or:   e.result = a | b;
					fn_xor:  e.result = a ^ b;
					fn_nor:  e.result = ~(a | b);
					fn_add:  e.result = a + b;
					fn_addu: e.result = a + b;
					fn_sub:  e.result = a - b;
					fn_subu: e.result = a - b;
					fn_slt:  e.result = flag_word($signed(a) < $signed(b));
					fn_sltu: e.result = flag_word(a < b);
					fn_movn: begin
						e.result = a;
						e.wr_en = (b != '0);	// Conditional move
					end
					default: e.wr_en = 1'b0;
				endcase
			end
			op_regimm: begin
				if (w[20:16] == 5'd1) begin	// BGEZ
					e.result = flag_word(!a[31]);
					e.branch = !a[31];
				end
			end
			op_beq: begin
				e.result = a - b;
				e.branch = (a == b);
			end
			op_bne: begin
				e.result = a - b;
				e.branch = (a != b);
			end
			op_addi:  e.result = a + sx;
			op_addiu: e.result = a + sx;
			op_slti:  e.result = flag_word($signed(a) < $signed(sx));
			op_sltiu: e.result = flag_word(a < sx);
			op_andi:  e.result = a & zx;
			op_ori:   e.result = a | zx;
			op_xori:  e.result = a ^ zx;
			op_lui:   e.result = {w[15:0], 16'h0};
			default: ;
		endcase
		if (w[31:26] inside {op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori,
				op_xori, op_lui}) begin
			e.wr_en = 1'b1;
		end
		if (e.wr_addr == '0) begin
			e.wr_en = 1'b0;	// r0 is never written
		end
		return e;
	endfunction

	task automatic compare_outputs(input expect_t e);
		if (cycle_count != e.cycle + 32'd2) begin
			other_count++;
			$display("result for instr %h came %0d cycles after its strobe instead of 2",
				e.instr, cycle_count - e.cycle);
		end
		if (result !== e.result) begin
			mismatch_count++;
			$display("Mismatch result: got %h expected %h (instr %h)", result, e.result, e.instr);
		end
		if (wr_en !== e.wr_en) begin
			mismatch_count++;
			$display("Mismatch wr_en: got %h expected %h (instr %h)", wr_en, e.wr_en, e.instr);
		end
		if (e.wr_en && wr_addr !== e.wr_addr) begin
			mismatch_count++;
			$display("Mismatch wr_addr: got %h expected %h (instr %h)", wr_addr, e.wr_addr,
				e.instr);
		end
		if (branch_taken !== e.branch) begin
			mismatch_count++;
			$display("Mismatch branch_taken: got %h expected %h (instr %h)", branch_taken,
				e.branch, e.instr);
		end
		checked_count++;
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle_count <= '0;
		end else begin
			cycle_count <= cycle_count + 32'd1;
		end
	end

	// Mid-cycle sampling, inputs and outputs both settled
	always @(negedge clk) begin
		expect_t e;
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				model[i] = '0;	// Matches register reset
			end
			pending.delete();
			checked_count = 0;
			mismatch_count = 0;
			other_count = 0;
		end else begin
			if (result_valid) begin
				if (pending.size() == 0) begin
					other_count++;
					$display("result_valid with no instruction in flight at cycle %0d",
						cycle_count);
				end else begin
					e = pending.pop_front();
					compare_outputs(e);
				end
			end else if (wr_en || branch_taken) begin
				other_count++;
				$display("wr_en or branch_taken high without result_valid at cycle %0d",
					cycle_count);
			end
			if (instr_strobe) begin
				e = predict(instr);
				e.cycle = cycle_count;
				pending.push_back(e);
				if (e.wr_en) begin
					model[e.wr_addr] = e.result;	// Visible to the next strobe
				end
			end
		end
	end

endmodule

// File: hdl/exec_core.sv
`timescale 1ns/1ps

module exec_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_strobe,
	input  exec_pkg::word_t     instr,
	output logic                result_valid,
	output exec_pkg::word_t     result,
	output logic                wr_en,
	output exec_pkg::reg_addr_t wr_addr,
	output logic                branch_taken
);
	import exec_pkg::*;

	alu_op_e operation;	// Decoder outputs
	logic equal;
	logic use_imm;
	logic imm_signed;
	logic dest_rt;
	logic write_allowed;
	logic is_branch;

	word_t rs_data;
	word_t rt_data;

	logic valid_q;	// Issue stage registers
	word_t a_q;
	word_t b_q;
	alu_op_e op_q;
	logic equal_q;
	reg_addr_t dest_q;
	logic write_allowed_q;
	logic is_branch_q;

	word_t alu_result;
	logic alu_zero;
	logic alu_movn;

	alu_control alu_control_inst (.instr, .operation, .equal, .use_imm, .imm_signed,
		.dest_rt, .write_allowed, .is_branch);

	register_file register_file_inst (.clk, .rst_n, .rs_addr(instr[25:21]),
		.rt_addr(instr[20:16]), .rs_data, .rt_data, .wr_en, .wr_addr, .wr_data(result));

	issue_stage issue_stage_inst (.clk, .rst_n, .instr_strobe, .instr, .rs_data, .rt_data,
		.operation, .equal, .use_imm, .imm_signed, .dest_rt, .write_allowed, .is_branch,
		.valid_q, .a_q, .b_q, .op_q, .equal_q, .dest_q, .write_allowed_q, .is_branch_q);

	alu alu_inst (.a(a_q), .b(b_q), .operation(op_q), .equal(equal_q),
		.result(alu_result), .alu_zero, .movn(alu_movn));

	writeback_stage writeback_stage_inst (.clk, .rst_n, .valid_q, .op_q, .dest_q,
		.write_allowed_q, .is_branch_q, .alu_result, .alu_zero, .alu_movn,
		.result_valid, .result, .wr_en, .wr_addr, .branch_taken);

endmodule

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                valid_q,
	input  exec_pkg::alu_op_e   op_q,
	input  exec_pkg::reg_addr_t dest_q,
	input  logic                write_allowed_q,
	input  logic                is_branch_q,
	input  exec_pkg::word_t     alu_result,
	input  logic                alu_zero,
	input  logic                alu_movn,
	output logic                result_valid,
	output exec_pkg::word_t     result,
	output logic                wr_en,
	output exec_pkg::reg_addr_t wr_addr,
	output logic                branch_taken
);
	import exec_pkg::*;

	logic do_write;

	// No r0 writes, MOVN only with rt nonzero
	assign do_write = valid_q && write_allowed_q && (dest_q != '0) &&
		(op_q != movn_op || alu_movn);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			wr_en <= 1'b0;
			branch_taken <= 1'b0;
		end else begin
			result_valid <= valid_q;	// Strobe plus two cycles
			wr_en <= do_write;
			branch_taken <= valid_q && is_branch_q && alu_zero;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_q) begin
			result <= alu_result;
			wr_addr <= dest_q;
		end
	end

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_strobe,
	input  exec_pkg::word_t     instr,
	input  exec_pkg::word_t     rs_data,
	input  exec_pkg::word_t     rt_data,
	input  exec_pkg::alu_op_e   operation,
	input  logic                equal,
	input  logic                use_imm,
	input  logic                imm_signed,
	input  logic                dest_rt,
	input  logic                write_allowed,
	input  logic                is_branch,
	output logic                valid_q,
	output exec_pkg::word_t     a_q,
	output exec_pkg::word_t     b_q,
	output exec_pkg::alu_op_e   op_q,
	output logic                equal_q,
	output exec_pkg::reg_addr_t dest_q,
	output logic                write_allowed_q,
	output logic                is_branch_q
);
	import exec_pkg::*;

	word_t imm;	// Extended immediate
	word_t b_sel;
	reg_addr_t dest;

	assign imm = imm_signed ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
	assign b_sel = use_imm ? imm : rt_data;
	assign dest = dest_rt ? instr[20:16] : instr[15:11];	// rt or rd

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			op_q <= bad_op;
			a_q <= '0;
			b_q <= '0;
			write_allowed_q <= 1'b0;
			is_branch_q <= 1'b0;
		end else begin
			valid_q <= instr_strobe;	// One cycle per strobe
			if (instr_strobe) begin
				op_q <= operation;
				a_q <= rs_data;
				b_q <= b_sel;
				write_allowed_q <= write_allowed;
				is_branch_q <= is_branch;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instr_strobe) begin
			equal_q <= equal;
			dest_q <= dest;
		end
	end

	// Operands and destination must be known when captured
	a_decode_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		instr_strobe |-> !$isunknown({rs_data, b_sel, dest})
	) else $error("issue_stage: unknown operand or destination for instr %h", instr);

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                clk,
	input  logic                rst_n,
	input  exec_pkg::reg_addr_t rs_addr,
	input  exec_pkg::reg_addr_t rt_addr,
	output exec_pkg::word_t     rs_data,
	output exec_pkg::word_t     rt_data,
	input  logic                wr_en,
	input  exec_pkg::reg_addr_t wr_addr,
	input  exec_pkg::word_t     wr_data
);
	import exec_pkg::*;

	word_t regs [32];	// regs[0] stays zero

	// Write port, r0 never written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;	// All registers clear
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads see a write landing in the same cycle
	assign rs_data = (rs_addr == '0) ? '0 :
		(wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 :
		(wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

	// Writeback must filter r0 destinations
	a_no_r0_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(wr_en && wr_addr == '0)
	) else $error("register_file: write strobe to r0");

endmodule

// File: hdl/alu_control.sv
`timescale 1ns/1ps

module alu_control (
	input  exec_pkg::word_t   instr,
	output exec_pkg::alu_op_e operation,
	output logic              equal,		// BEQ sense
	output logic              use_imm,		// B from immediate
	output logic              imm_signed,	// Sign-extend immediate
	output logic              dest_rt,		// Destination is rt
	output logic              write_allowed,
	output logic              is_branch
);
	import exec_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t rt;
	logic i_type;	// Immediate arithmetic/logic form

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rt = instr[20:16];

	always_comb begin
		operation = bad_op;	// Unknown unless matched
		equal = 1'b0;
		imm_signed = 1'b0;
		write_allowed = 1'b0;
		is_branch = 1'b0;
		i_type = 1'b0;

		case (opcode)
			op_rtype: begin
				write_allowed = 1'b1;
				case (funct)
					fn_and:  operation = and_op;
					fn_or:   operation = or_op;
					fn_xor:  operation = xor_op;
					fn_nor:  operation = nor_op;
					fn_add:  operation = add_op;
					fn_addu: operation = addu_op;
					fn_sub:  operation = sub_op;
					fn_subu: operation = subu_op;
					fn_slt:  operation = slt_op;
					fn_sltu: operation = sltu_op;
					fn_movn: operation = movn_op;
					default: write_allowed = 1'b0;	// Unknown funct
				endcase
			end
			op_regimm: begin
				if (rt == 5'd1) begin	// BGEZ only
					operation = bgez_op;
					is_branch = 1'b1;
				end
			end
			op_beq: begin
				operation = sub_op;
				equal = 1'b1;
				is_branch = 1'b1;
			end
			op_bne: begin
				operation = sub_op;
				is_branch = 1'b1;
			end
			op_addi:  begin operation = add_op;  imm_signed = 1'b1; i_type = 1'b1; end
			op_addiu: begin operation = addu_op; imm_signed = 1'b1; i_type = 1'b1; end
			op_slti:  begin operation = slt_op;  imm_signed = 1'b1; i_type = 1'b1; end
			op_sltiu: begin operation = sltu_op; imm_signed = 1'b1; i_type = 1'b1; end
			op_andi:  begin operation = and_op;  i_type = 1'b1; end	// Zero-extended
			op_ori:   begin operation = or_op;   i_type = 1'b1; end
			op_xori:  begin operation = xor_op;  i_type = 1'b1; end
			op_lui:   begin operation = lui_op;  i_type = 1'b1; end
			default: ;	// bad_op, no write, no branch
		endcase

		if (i_type) begin
			write_allowed = 1'b1;
		end
	end

	assign use_imm = i_type;
	assign dest_rt = i_type;	// I-type writes rt

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  exec_pkg::word_t   a,		// rs operand
	input  exec_pkg::word_t   b,		// rt or immediate
	input  exec_pkg::alu_op_e operation,
	input  logic              equal,	// BEQ high, BNE low
	output exec_pkg::word_t   result,
	output logic              alu_zero,	// Branch condition met
	output logic              movn		// MOVN write permitted
);
	import exec_pkg::*;

	always_comb begin
		result = '0;
		alu_zero = 1'b0;
		movn = 1'b0;

		case (operation)
			and_op: begin
				result = a & b;
			end
			or_op: begin
				result = a | b;
			end
			add_op: begin
				result = word_t'($signed(a) + $signed(b));	// Overflow ignored
			end
			addu_op: begin
				result = a + b;
			end
			movn_op: begin
				result = a;	// rd <- rs
				movn = (b != '0);	// Only when rt nonzero
			end
			sub_op: begin
				result = a - b;
				// Equality compare, sense flipped for BNE
				alu_zero = (a == b) ~^ equal;
			end
			subu_op: begin
				result = a - b;
			end
			bgez_op: begin
				result = {31'b0, ~a[31]};	// 1 when rs >= 0
				alu_zero = ~a[31];
			end
			slt_op: begin
				result = {31'b0, $signed(a) < $signed(b)};	// Signed compare
			end
			sltu_op: begin
				result = {31'b0, a < b};	// Unsigned compare
			end
			nor_op: begin
				result = ~(a | b);
			end
			xor_op: begin
				result = a ^ b;
			end
			lui_op: begin
				result = b << 16;	// Immediate to upper half
			end
			default: begin
				result = bad_result;	// Undefined or bad_op
			end
		endcase
	end

	// Issue stage keeps operands known, so any decoded op yields a known word
	always_comb begin
		if (!$isunknown(operation) && operation != bad_op) begin
			assert (!$isunknown(result))
				else $error("alu: unknown result for operation %0d", operation);
		end
	end

endmodule

// File: hdl/exec_pkg.sv
package exec_pkg;

	typedef logic [31:0] word_t;	// Operand or result word
	typedef logic [4:0] reg_addr_t;	// Register index

	// ALU operation codes
	typedef enum logic [3:0] {
		and_op  = 4'd0,
		or_op   = 4'd1,
		add_op  = 4'd2,		// Signed add, no trap
		addu_op = 4'd3,
		movn_op = 4'd4,		// Pass rs, flag rt nonzero
		sub_op  = 4'd6,		// Also BEQ/BNE compare
		subu_op = 4'd7,
		bgez_op = 4'd8,
		slt_op  = 4'd9,
		sltu_op = 4'd10,
		nor_op  = 4'd12,
		xor_op  = 4'd13,
		bad_op  = 4'd14,	// Falls to ALU default
		lui_op  = 4'd15
	} alu_op_e;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_regimm = 6'h01;	// BGEZ when rt is 1
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti = 6'h0a;
	localparam logic [5:0] op_sltiu = 6'h0b;
	localparam logic [5:0] op_andi = 6'h0c;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_xori = 6'h0e;
	localparam logic [5:0] op_lui = 6'h0f;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] fn_movn = 6'h0b;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_xor = 6'h26;
	localparam logic [5:0] fn_nor = 6'h27;
	localparam logic [5:0] fn_slt = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

	localparam word_t bad_result = 32'hdeadbeef;	// Marks an undefined operation

endpackage
